// File: sim.f
logic/snes_cart_pkg.sv
logic/header_detect.sv
logic/cheat_code_collector.sv
logic/backup_sequencer.sv
logic/cart_loader_top.sv
testbench/cart_loader_properties.sv
testbench/tb_cart_loader.sv

// File: Bender.yml
package:
  name: cart_loader

sources:
  - logic/snes_cart_pkg.sv
  - logic/header_detect.sv
  - logic/cheat_code_collector.sv
  - logic/backup_sequencer.sv
  - logic/cart_loader_top.sv
  - target: test
    files:
      - testbench/cart_loader_properties.sv
      - testbench/tb_cart_loader.sv

// File: testbench/tb_cart_loader.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cart_loader;

	localparam int LBA_WIDTH  = 16;
	localparam int WAIT_LIMIT = 400;

	typedef struct packed {
		snes_cart_pkg::header_mode_e mode;
		snes_cart_pkg::region_sel_e  region;
		logic [15:0]                 word0;
		logic [15:0]                 word2;
		logic [3:0]                  rom_size;
		logic [3:0]                  ram_size;
		logic [7:0]                  exp_type;
		logic [23:0]                 exp_rom_mask;
		logic [23:0]                 exp_ram_mask;
		logic                        exp_pal;
	} header_case_t;

	logic                        clk_sys = 1'b0;
	logic                        reset;
	snes_cart_pkg::dl_word_t     dl_word;
	logic                        dl_valid;
	logic                        download_active;
	logic                        dl_ready;
	snes_cart_pkg::header_mode_e header_mode;
	snes_cart_pkg::region_sel_e  region_sel;
	snes_cart_pkg::cart_info_t   cart_info;
	snes_cart_pkg::cheat_code_t  code;
	logic                        code_valid;
	logic                        code_ready;
	logic                        cheat_clear;
	snes_cart_pkg::image_info_t  image;
	logic                        load_req;
	logic                        save_req;
	logic                        bram_write;
	logic [LBA_WIDTH-1:0]        sd_lba;
	logic                        sd_rd;
	logic                        sd_wr;
	logic                        sd_ack;
	logic                        busy;
	logic                        bk_enabled;
	logic                        dirty;

	header_case_t case_table [5];
	int           lba_log [$];
	logic         read_log [$];
	int           check_count = 0;
	int           error_count = 0;

	cart_loader_top #(.LBA_WIDTH(LBA_WIDTH)) i_cart_loader_top (.*);

	always #20 clk_sys = ~clk_sys;

	// ==================================================================
	// Helpers
	// ==================================================================
	task automatic compare_values(input string what, input logic [127:0] got,
		input logic [127:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("[ERROR] %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	task automatic abort_run(input string what);
		$display("Timeout while waiting for %s", what);
		$display("ERRORS FOUND");
		$finish;
	endtask

	function automatic snes_cart_pkg::dl_addr_t size_byte_addr(
		input snes_cart_pkg::header_mode_e mode);
		case (mode)
			snes_cart_pkg::hdr_lorom:   return 25'h0081D6;
			snes_cart_pkg::hdr_hirom:   return 25'h0101D6;
			snes_cart_pkg::hdr_exhirom: return 25'h4101D6;
			default:                    return 25'h0;
		endcase
	endfunction

	// Called 2 ns after an edge, returns 2 ns after the edge that took the word
	task automatic send_word(input logic [7:0] index, input snes_cart_pkg::dl_addr_t addr,
		input logic [15:0] data);
		int waited;
		waited = 0;
		dl_word = '{index: index, addr: addr, data: data};
		dl_valid = 1'b1;
		while (!dl_ready) begin
			@(posedge clk_sys);
			#2;
			waited++;
			if (waited > WAIT_LIMIT) abort_run("dl_ready on the download stream");
		end
		@(posedge clk_sys);
		#2;
		dl_valid = 1'b0;
	endtask

	task automatic wait_busy(input logic level, input string what);
		int waited;
		waited = 0;
		while (busy !== level) begin
			@(posedge clk_sys);
			#2;
			waited++;
			if (waited > WAIT_LIMIT) abort_run(what);
		end
	endtask

	task automatic load_cartridge(input header_case_t c);
		snes_cart_pkg::dl_addr_t size_addr;
		int waited;
		size_addr = size_byte_addr(c.mode);
		waited = 0;
		header_mode = c.mode;
		region_sel = c.region;
		download_active = 1'b1;
		send_word(8'h00, 25'd0, c.word0);
		compare_values("loading during download", cart_info.loading, 1'b1);
		send_word(8'h00, 25'd2, c.word2);
		for (int a = 4; a <= 10; a += 2) begin
			send_word(8'h00, 25'(a), 16'($urandom));
		end
		// Size code in both byte lanes
		if (size_addr != '0) begin
			send_word(8'h00, size_addr, {4'h0, c.rom_size, 4'h0, c.rom_size});
			send_word(8'h00, size_addr + 25'd2, {4'h0, c.ram_size, 4'h0, c.ram_size});
		end
		download_active = 1'b0;
		while (cart_info.loading) begin
			@(posedge clk_sys);
			#2;
			waited++;
			if (waited > WAIT_LIMIT) abort_run("cartridge loading to end");
		end
		// pal follows the region one cycle after loading drops
		@(posedge clk_sys);
		#2;
		compare_values("rom type", cart_info.rom_type, c.exp_type);
		compare_values("rom mask", cart_info.rom_mask, c.exp_rom_mask);
		compare_values("ram mask", cart_info.ram_mask, c.exp_ram_mask);
		compare_values("pal", cart_info.pal, c.exp_pal);
	endtask

	task automatic take_record(input snes_cart_pkg::cheat_code_t expected);
		int waited;
		int stall;
		waited = 0;
		while (!code_valid) begin
			@(posedge clk_sys);
			#2;
			waited++;
			if (waited > WAIT_LIMIT) abort_run("a cheat record");
		end
		compare_values("cheat record", code, expected);
		stall = $urandom_range(12, 3);
		for (int s = 0; s < stall; s++) begin
			@(posedge clk_sys);
			#2;
			compare_values("stream stalled", dl_ready, 1'b0);
		end
		code_ready = 1'b1;
		@(posedge clk_sys);
		#2;
		code_ready = 1'b0;
		compare_values("record taken", code_valid, 1'b0);
	endtask

	task automatic run_cheat_file();
		logic [15:0]                words [16];
		snes_cart_pkg::cheat_code_t expected [2];
		for (int i = 0; i < 16; i++) begin
			words[i] = 16'($urandom);
		end
		// Low half of each field first
		for (int r = 0; r < 2; r++) begin
			expected[r].flags   = {words[8*r+1], words[8*r]};
			expected[r].address = {words[8*r+3], words[8*r+2]};
			expected[r].compare = {words[8*r+5], words[8*r+4]};
			expected[r].replace = {words[8*r+7], words[8*r+6]};
		end
		download_active = 1'b1;
		fork
			for (int i = 0; i < 16; i++) begin
				send_word(8'hFF, 25'(2 * i), words[i]);
				if (i == 0) compare_values("cheat_clear", cheat_clear, 1'b1);
			end
			for (int r = 0; r < 2; r++) begin
				take_record(expected[r]);
			end
		join
		download_active = 1'b0;
	endtask

	task automatic check_requests(input logic is_read, input int blocks);
		compare_values("request count", lba_log.size(), blocks);
		foreach (lba_log[i]) begin
			compare_values("request block number", lba_log[i], i);
			compare_values("request direction", read_log[i], is_read);
		end
	endtask

	// ==================================================================
	// Storage model
	// ==================================================================
	initial begin : storage_model
		sd_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			if (sd_rd || sd_wr) begin
				lba_log.push_back(int'(sd_lba));
				read_log.push_back(sd_rd);
				repeat (3) @(posedge clk_sys);
				#2 sd_ack = 1'b1;
				repeat (2) @(posedge clk_sys);
				#2 sd_ack = 1'b0;
			end
		end
	end

	// ==================================================================
	// Main sequence
	// ==================================================================
	initial begin : main
		header_case_t ram_cart;
		header_case_t flat_cart;
		int           blocks;
		void'($urandom(59));
		reset = 1'b0;
		dl_word = '0;
		dl_valid = 1'b0;
		download_active = 1'b0;
		header_mode = snes_cart_pkg::hdr_auto;
		region_sel = snes_cart_pkg::region_auto;
		code_ready = 1'b0;
		image = '0;
		load_req = 1'b0;
		save_req = 1'b0;
		bram_write = 1'b0;

		case_table[0] = '{snes_cart_pkg::hdr_auto, snes_cart_pkg::region_auto, 16'h0523,
			16'h0100, 4'd0, 4'd0, 8'h05, 24'h001FFF, 24'h000FFF, 1'b1};
		case_table[1] = '{snes_cart_pkg::hdr_no_header, snes_cart_pkg::region_ntsc, 16'hA5C3,
			16'h0100, 4'd0, 4'd0, 8'h00, 24'h3FFFFF, 24'h000000, 1'b0};
		case_table[2] = '{snes_cart_pkg::hdr_lorom, snes_cart_pkg::region_auto, 16'h1234,
			16'h0000, 4'd10, 4'd3, 8'h00, 24'h0FFFFF, 24'h001FFF, 1'b0};
		case_table[3] = '{snes_cart_pkg::hdr_hirom, snes_cart_pkg::region_pal, 16'h0000,
			16'h0000, 4'd11, 4'd0, 8'h01, 24'h1FFFFF, 24'h000000, 1'b1};
		case_table[4] = '{snes_cart_pkg::hdr_exhirom, snes_cart_pkg::region_auto, 16'h7711,
			16'h0100, 4'd13, 4'd5, 8'h02, 24'h7FFFFF, 24'h007FFF, 1'b1};
		ram_cart = '{snes_cart_pkg::hdr_auto, snes_cart_pkg::region_auto, 16'h0118,
			16'h0000, 4'd0, 4'd0, 8'h01, 24'h03FFFF, 24'h0007FF, 1'b0};
		flat_cart = '{snes_cart_pkg::hdr_no_header, snes_cart_pkg::region_auto, 16'h0000,
			16'h0000, 4'd0, 4'd0, 8'h00, 24'h3FFFFF, 24'h000000, 1'b0};

		repeat (16) @(posedge clk_sys);
		#2 reset = 1'b1;
		compare_values("dl_ready after reset", dl_ready, 1'b1);
		compare_values("code_valid after reset", code_valid, 1'b0);
		compare_values("cheat_clear after reset", cheat_clear, 1'b0);
		compare_values("sd_rd after reset", sd_rd, 1'b0);
		compare_values("sd_wr after reset", sd_wr, 1'b0);
		compare_values("busy after reset", busy, 1'b0);
		compare_values("bk_enabled after reset", bk_enabled, 1'b0);
		compare_values("dirty after reset", dirty, 1'b0);

		for (int i = 0; i < 5; i++) begin
			load_cartridge(case_table[i]);
		end
		run_cheat_file();

		// Cartridge RAM on a writable image with data
		image.mounted = 1'b1;
		image.readonly = 1'b0;
		image.has_data = 1'b1;
		blocks = int'(ram_cart.exp_ram_mask >> 9) + 1;
		lba_log.delete();
		read_log.delete();
		load_cartridge(ram_cart);
		compare_values("bk_enabled with RAM", bk_enabled, 1'b1);
		wait_busy(1'b1, "the automatic load to start");
		wait_busy(1'b0, "the automatic load to finish");
		check_requests(1'b1, blocks);

		bram_write = 1'b1;
		@(posedge clk_sys);
		#2 bram_write = 1'b0;
		compare_values("dirty after write", dirty, 1'b1);
		lba_log.delete();
		read_log.delete();
		save_req = 1'b1;
		@(posedge clk_sys);
		#2 save_req = 1'b0;
		wait_busy(1'b1, "the save to start");
		compare_values("dirty after save start", dirty, 1'b0);
		wait_busy(1'b0, "the save to finish");
		check_requests(1'b0, blocks);

		// No RAM means no storage traffic at all
		lba_log.delete();
		read_log.delete();
		load_cartridge(flat_cart);
		compare_values("bk_enabled without RAM", bk_enabled, 1'b0);
		load_req = 1'b1;
		@(posedge clk_sys);
		#2 load_req = 1'b0;
		save_req = 1'b1;
		@(posedge clk_sys);
		#2 save_req = 1'b0;
		repeat (20) @(posedge clk_sys);
		#2;
		compare_values("requests without RAM", lba_log.size(), 0);
		compare_values("busy without RAM", busy, 1'b0);

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/cart_loader_properties.sv
`timescale 1ns/1ns
`default_nettype none

module cart_loader_properties (
	input logic                       clk_sys,
	input logic                       reset,
	input logic                       sd_rd,
	input logic                       sd_wr,
	input logic                       dl_ready,
	input logic                       code_valid,
	input logic                       code_ready,
	input snes_cart_pkg::cheat_code_t code,
	input logic                       cheat_clear,
	input logic                       loading
);

	// One storage direction at a time
	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!reset)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr are high together");

	// Back-pressure mirrors the pending record
	ready_tracks_valid: assert property (@(posedge clk_sys) disable iff (!reset)
		dl_ready == !code_valid)
		else $error("dl_ready does not track code_valid");

	code_held: assert property (@(posedge clk_sys) disable iff (!reset)
		code_valid && !code_ready |=> $stable(code))
		else $error("cheat record changed while waiting to be taken");

	clear_single_cycle: assert property (@(posedge clk_sys) disable iff (!reset)
		cheat_clear && !loading |=> !cheat_clear)
		else $error("cheat_clear longer than one cycle outside loading");

endmodule

bind cart_loader_top cart_loader_properties i_cart_loader_properties (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.sd_rd       (sd_rd),
	.sd_wr       (sd_wr),
	.dl_ready    (dl_ready),
	.code_valid  (code_valid),
	.code_ready  (code_ready),
	.code        (code),
	.cheat_clear (cheat_clear),
	.loading     (cart_info.loading)
);

`default_nettype wire

// File: logic/cart_loader_top.sv
`timescale 1ns/1ns
`default_nettype none

module cart_loader_top #(
	parameter int LBA_WIDTH = 16
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	// Download stream
	input  snes_cart_pkg::dl_word_t     dl_word,
	input  logic                        dl_valid,
	input  logic                        download_active,
	output logic                        dl_ready,
	// Cartridge setup
	input  snes_cart_pkg::header_mode_e header_mode,
	input  snes_cart_pkg::region_sel_e  region_sel,
	output snes_cart_pkg::cart_info_t   cart_info,
	// Cheat records
	output snes_cart_pkg::cheat_code_t  code,
	output logic                        code_valid,
	input  logic                        code_ready,
	output logic                        cheat_clear,
	// Backup RAM storage
	input  snes_cart_pkg::image_info_t  image,
	input  logic                        load_req,
	input  logic                        save_req,
	input  logic                        bram_write,
	output logic [LBA_WIDTH-1:0]        sd_lba,
	output logic                        sd_rd,
	output logic                        sd_wr,
	input  logic                        sd_ack,
	output logic                        busy,
	output logic                        bk_enabled,
	output logic                        dirty
);

	header_detect i_header_detect (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.dl_word         (dl_word),
		.dl_valid        (dl_valid),
		.dl_ready        (dl_ready),
		.download_active (download_active),
		.header_mode     (header_mode),
		.region_sel      (region_sel),
		.cart_info       (cart_info)
	);

	cheat_code_collector i_cheat_code_collector (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.dl_word         (dl_word),
		.dl_valid        (dl_valid),
		.download_active (download_active),
		.cart_loading    (cart_info.loading),
		.dl_ready        (dl_ready),
		.code            (code),
		.code_valid      (code_valid),
		.code_ready      (code_ready),
		.cheat_clear     (cheat_clear)
	);

	backup_sequencer #(
		.LBA_WIDTH (LBA_WIDTH)
	) i_backup_sequencer (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.cart_info  (cart_info),
		.image      (image),
		.load_req   (load_req),
		.save_req   (save_req),
		.bram_write (bram_write),
		.sd_lba     (sd_lba),
		.sd_rd      (sd_rd),
		.sd_wr      (sd_wr),
		.sd_ack     (sd_ack),
		.busy       (busy),
		.bk_enabled (bk_enabled),
		.dirty      (dirty)
	);

endmodule

`default_nettype wire

// File: logic/backup_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module backup_sequencer #(
	parameter int LBA_WIDTH = 16
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  snes_cart_pkg::cart_info_t  cart_info,
	input  snes_cart_pkg::image_info_t image,
	input  logic                       load_req,
	input  logic                       save_req,
	input  logic                       bram_write,
	output logic [LBA_WIDTH-1:0]       sd_lba,
	output logic                       sd_rd,
	output logic                       sd_wr,
	input  logic                       sd_ack,
	output logic                       busy,
	output logic                       bk_enabled,
	output logic                       dirty
);

	snes_cart_pkg::bk_state_e state;
	logic                     loading_d;
	logic                     load_d;
	logic                     save_d;
	logic                     ack_d;
	logic                     is_load;
	logic                     load_start;
	logic                     load_end;
	logic                     load_rise;
	logic                     save_rise;
	logic                     auto_load;
	logic                     start;
	logic                     start_load;
	logic [LBA_WIDTH-1:0]     last_lba;

	assign load_start = cart_info.loading && !loading_d;
	assign load_end   = !cart_info.loading && loading_d;
	assign load_rise  = load_req && !load_d;
	assign save_rise  = save_req && !save_d;

	// Fresh cartridge pulls its save from the image right away
	assign auto_load  = load_end && image.has_data;
	assign start_load = load_rise || auto_load;
	assign start      = bk_enabled && (state == snes_cart_pkg::bk_idle) &&
		(start_load || save_rise);

	// One block per 512 bytes of cartridge RAM
	assign last_lba = LBA_WIDTH'(cart_info.ram_mask >> snes_cart_pkg::BLOCK_BYTES_LOG2);
	assign busy     = (state != snes_cart_pkg::bk_idle);

	// ==================================================================
	// Enable and dirty tracking
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			loading_d  <= 1'b0;
			load_d     <= 1'b0;
			save_d     <= 1'b0;
			ack_d      <= 1'b0;
			bk_enabled <= 1'b0;
			dirty      <= 1'b0;
		end else begin
			loading_d <= cart_info.loading;
			load_d    <= load_req;
			save_d    <= save_req;
			ack_d     <= sd_ack;

			if (load_start) begin
				bk_enabled <= 1'b0;
			end
			// Image is mounted by the time the cartridge streams in
			if (cart_info.loading && image.mounted && !image.readonly) begin
				bk_enabled <= |cart_info.ram_mask;
			end

			if (start) begin
				dirty <= 1'b0;
			end else if (bram_write && bk_enabled) begin
				dirty <= 1'b1;
			end
		end
	end

	// ==================================================================
	// Block transfer FSM
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state <= snes_cart_pkg::bk_idle;
			sd_rd <= 1'b0;
			sd_wr <= 1'b0;
		end else begin
			case (state)
				snes_cart_pkg::bk_idle: begin
					if (start) begin
						is_load <= start_load;
						sd_lba  <= '0;
						sd_rd   <= start_load;
						sd_wr   <= !start_load;
						state   <= snes_cart_pkg::bk_request;
					end
				end
				snes_cart_pkg::bk_request: begin
					// Storage side took the block
					if (sd_ack && !ack_d) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= snes_cart_pkg::bk_wait_release;
					end
				end
				snes_cart_pkg::bk_wait_release: begin
					if (!sd_ack) begin
						if (sd_lba >= last_lba) begin
							state <= snes_cart_pkg::bk_idle;
						end else begin
							sd_lba <= sd_lba + LBA_WIDTH'(1);
							sd_rd  <= is_load;
							sd_wr  <= !is_load;
							state  <= snes_cart_pkg::bk_request;
						end
					end
				end
				default: state <= snes_cart_pkg::bk_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: logic/cheat_code_collector.sv
`timescale 1ns/1ns
`default_nettype none

module cheat_code_collector (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  snes_cart_pkg::dl_word_t    dl_word,
	input  logic                       dl_valid,
	input  logic                       download_active,
	input  logic                       cart_loading,
	output logic                       dl_ready,
	output snes_cart_pkg::cheat_code_t code,
	output logic                       code_valid,
	input  logic                       code_ready,
	output logic                       cheat_clear
);

	logic cheat_active;
	logic cheat_xfer;

	assign cheat_active = download_active && (dl_word.index == snes_cart_pkg::CHEAT_INDEX);

	// Stream stalls while a finished record waits to be taken
	assign dl_ready   = !code_valid;
	assign cheat_xfer = dl_valid && dl_ready && cheat_active;

	// ==================================================================
	// Record assembly
	// ==================================================================
	// Bottom half of each field arrives first
	always_ff @(posedge clk_sys) begin
		if (cheat_xfer) begin
			case (dl_word.addr[3:0])
				4'd0:  code.flags[15:0]    <= dl_word.data;
				4'd2:  code.flags[31:16]   <= dl_word.data;
				4'd4:  code.address[15:0]  <= dl_word.data;
				4'd6:  code.address[31:16] <= dl_word.data;
				4'd8:  code.compare[15:0]  <= dl_word.data;
				4'd10: code.compare[31:16] <= dl_word.data;
				4'd12: code.replace[15:0]  <= dl_word.data;
				4'd14: code.replace[31:16] <= dl_word.data;
				default: ;
			endcase
		end
	end

	// ==================================================================
	// Handoff and clear
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			code_valid  <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			if (cheat_xfer && dl_word.addr[3:0] == 4'd14) begin
				code_valid <= 1'b1;
			end else if (code_ready) begin
				code_valid <= 1'b0;
			end

			// New cheat file or any cartridge load wipes the table
			cheat_clear <= (cheat_xfer && dl_word.addr == '0) || cart_loading;
		end
	end

endmodule

`default_nettype wire

// File: logic/header_detect.sv
`timescale 1ns/1ns
`default_nettype none

module header_detect (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  snes_cart_pkg::dl_word_t     dl_word,
	input  logic                        dl_valid,
	input  logic                        dl_ready,
	input  logic                        download_active,
	input  snes_cart_pkg::header_mode_e header_mode,
	input  snes_cart_pkg::region_sel_e  region_sel,
	output snes_cart_pkg::cart_info_t   cart_info
);

	logic                     cart_active;
	logic                     cart_xfer;
	logic                     use_header;
	snes_cart_pkg::dl_addr_t  size_addr;
	logic [3:0]               rom_size;
	logic [3:0]               ram_size;
	logic [3:0]               rom_size_next;
	logic [3:0]               ram_size_next;
	snes_cart_pkg::rom_type_t rom_type_next;
	logic                     rom_region;
	logic                     region_next;

	// 1 KiB shifted up by the header size code
	function automatic snes_cart_pkg::mem_mask_t size_to_mask(input logic [3:0] size);
		return (snes_cart_pkg::mem_mask_t'(1024) << size) - snes_cart_pkg::mem_mask_t'(1);
	endfunction

	assign cart_active = download_active && (dl_word.index != snes_cart_pkg::CHEAT_INDEX);
	assign cart_xfer   = dl_valid && dl_ready && cart_active;

	// Where the internal header sits for a forced mapping
	always_comb begin
		use_header = 1'b1;
		case (header_mode)
			snes_cart_pkg::hdr_lorom:   size_addr = snes_cart_pkg::HDR_LOROM;
			snes_cart_pkg::hdr_hirom:   size_addr = snes_cart_pkg::HDR_HIROM;
			snes_cart_pkg::hdr_exhirom: size_addr = snes_cart_pkg::HDR_EXHIROM;
			default: begin
				use_header = 1'b0;
				size_addr  = '0;
			end
		endcase
	end

	always_comb begin
		rom_size_next = rom_size;
		ram_size_next = ram_size;
		rom_type_next = cart_info.rom_type;
		region_next   = rom_region;

		// First word carries the copier size byte and the type in auto mode
		if (dl_word.addr == '0) begin
			rom_size_next = snes_cart_pkg::DEFAULT_ROM_SIZE;
			ram_size_next = 4'd0;
			if (header_mode == snes_cart_pkg::hdr_auto && dl_word.data[7:0] != 8'd0) begin
				{ram_size_next, rom_size_next} = dl_word.data[7:0];
			end
			case (header_mode)
				snes_cart_pkg::hdr_auto:    rom_type_next = dl_word.data[15:8];
				snes_cart_pkg::hdr_hirom:   rom_type_next = 8'd1;
				snes_cart_pkg::hdr_exhirom: rom_type_next = 8'd2;
				default:                    rom_type_next = 8'd0;
			endcase
		end

		if (dl_word.addr == snes_cart_pkg::dl_addr_t'(2)) begin
			region_next = dl_word.data[8];
		end

		if (use_header && dl_word.addr == size_addr) begin
			rom_size_next = dl_word.data[11:8];
		end
		// RAM size byte is the next word up
		if (use_header && dl_word.addr == size_addr + snes_cart_pkg::dl_addr_t'(2)) begin
			ram_size_next = dl_word.data[3:0];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cart_info  <= '0;
			rom_size   <= snes_cart_pkg::DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
			rom_region <= 1'b0;
		end else begin
			cart_info.loading <= cart_active;

			if (cart_xfer) begin
				rom_size           <= rom_size_next;
				ram_size           <= ram_size_next;
				rom_region         <= region_next;
				cart_info.rom_type <= rom_type_next;
				cart_info.rom_mask <= size_to_mask(rom_size_next);
				cart_info.ram_mask <= (ram_size_next == 4'd0) ? '0 : size_to_mask(ram_size_next);
			end

			// Region select wins over the header once the load is done
			if (!cart_info.loading) begin
				case (region_sel)
					snes_cart_pkg::region_auto: cart_info.pal <= rom_region;
					snes_cart_pkg::region_pal:  cart_info.pal <= 1'b1;
					default:                    cart_info.pal <= 1'b0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/snes_cart_pkg.sv
`default_nettype none

package snes_cart_pkg;

	// ==================================================================
	// Download stream
	// ==================================================================
	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] dl_data_t;
	typedef logic [7:0]  dl_index_t;

	typedef struct packed {
		dl_index_t index;
		dl_addr_t  addr;
		dl_data_t  data;
	} dl_word_t;

	// Cheat file download kind
	localparam dl_index_t CHEAT_INDEX = 8'hFF;

	// ==================================================================
	// Cartridge description
	// ==================================================================
	typedef logic [23:0] mem_mask_t;
	typedef logic [7:0]  rom_type_t;

	typedef struct packed {
		logic      loading;
		rom_type_t rom_type;
		mem_mask_t rom_mask;
		mem_mask_t ram_mask;
		logic      pal;
	} cart_info_t;

	typedef enum logic [2:0] {
		hdr_auto,
		hdr_no_header,
		hdr_lorom,
		hdr_hirom,
		hdr_exhirom
	} header_mode_e;

	typedef enum logic [1:0] {
		region_auto,
		region_ntsc,
		region_pal
	} region_sel_e;

	localparam int         COPIER_HEADER_BYTES = 512;
	localparam logic [3:0] DEFAULT_ROM_SIZE    = 4'd12;

	// ROM size byte of each internal header, copier header included
	localparam dl_addr_t HDR_LOROM   = dl_addr_t'(25'h007FD6 + COPIER_HEADER_BYTES);
	localparam dl_addr_t HDR_HIROM   = dl_addr_t'(25'h00FFD6 + COPIER_HEADER_BYTES);
	localparam dl_addr_t HDR_EXHIROM = dl_addr_t'(25'h40FFD6 + COPIER_HEADER_BYTES);

	// ==================================================================
	// Cheats and backup RAM
	// ==================================================================
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic mounted;
		logic readonly;
		logic has_data;
	} image_info_t;

	typedef enum logic [1:0] {
		bk_idle,
		bk_request,
		bk_wait_release
	} bk_state_e;

	localparam int BLOCK_BYTES_LOG2 = 9;

endpackage

`default_nettype wire
